/* common/cgmii_config.svh */
`ifndef CGMII_CONFIG_SVH
`define CGMII_CONFIG_SVH

// block and control widths
`define LEN_TX_DATA 64
`define LEN_TX_CTRL 8
`define LEN_CHAR    8
`define N_LANES     8

// CGMII characters
`define IDLE_CHAR 8'h07
`define TERM_CHAR 8'hFD

// control vectors, one bit per lane, lane 0 is the msb
`define IDLE_CTRL  8'hFF
`define DATA_CTRL  8'h00
`define START_CTRL 8'h80
`define ORD_CTRL   8'h80

// fixed blocks
`define START_BLOCK 64'hFB6879736963616C
`define ORD_BLOCK   64'h9C68797300000000

// ordered-set blocks sent after reset
`define INIT_BLOCKS 4

// frame length source
`define LEN_LFSR  16
`define LFSR_SEED 16'hACE1
`define LFSR_TAPS 16'hB400

// length field widths
`define NB_IDLE 5
`define NB_DATA 4
`define NB_TERM 3
`define NB_CNT  `NB_IDLE

`endif

/* common/cgmii_pkg.sv */
package cgmii_pkg;

	// frame sequencer states
	typedef enum logic [2:0]
	{
		ST_INIT  = 3'd0, // ordered sets after reset
		ST_IDLE  = 3'd1,
		ST_START = 3'd2,
		ST_DATA  = 3'd3,
		ST_TERM  = 3'd4
	} fsm_state_e;

	// kind of 64-bit block put on the CGMII lanes
	typedef enum logic [2:0]
	{
		BLK_ORD   = 3'd0,
		BLK_IDLE  = 3'd1,
		BLK_START = 3'd2,
		BLK_DATA  = 3'd3,
		BLK_TERM  = 3'd4
	} blk_kind_e;

endpackage

/* verilog/data_generator.sv */
`timescale 1ns/1ps
`include "cgmii_config.svh"

module data_generator
(
	input  logic                      i_clock,
	input  logic                      i_rst,
	input  logic                      i_enable,
	output logic [`LEN_TX_DATA-1:0]   o_data_block
);

localparam logic [`LEN_CHAR-1:0] STEP = `N_LANES;

logic [`LEN_CHAR-1:0] base; // byte value of lane 0

always_ff @(posedge i_clock)
begin
	if (i_rst)
		base <= '0;
	else if (i_enable)
		base <= base + STEP;  // wraps mod 256
end

// lane 0 sits in the top byte
always_comb
begin
	for (int lane = 0; lane < `N_LANES; lane++)
	begin
		o_data_block[`LEN_TX_DATA-1-lane*`LEN_CHAR -: `LEN_CHAR] =
			base + `LEN_CHAR'(lane);
	end
end

endmodule

/* verilog/frame_rand.sv */
`timescale 1ns/1ps
`include "cgmii_config.svh"

module frame_rand
(
	input  logic                   i_clock,
	input  logic                   i_rst,
	input  logic                   i_step,
	output logic [`NB_IDLE-1:0]    o_n_idle,
	output logic [`NB_DATA-1:0]    o_n_data,
	output logic [`NB_TERM-1:0]    o_n_term
);

logic [`LEN_LFSR-1:0] lfsr;

// galois form, shift right and fold taps back on a one
always_ff @(posedge i_clock)
begin
	if (i_rst)
		lfsr <= `LFSR_SEED;
	else if (i_step)
		lfsr <= (lfsr >> 1) ^ (lfsr[0] ? `LFSR_TAPS : '0);
end

// field slices, offset so no length is zero
assign o_n_idle = {1'b0, lfsr[3:0]} + `NB_IDLE'(1); // 1..16
assign o_n_data = {1'b0, lfsr[6:4]} + `NB_DATA'(1); // 1..8
assign o_n_term = lfsr[9:7];

endmodule

/* frame_gen/cgmii_fsm.sv */
`timescale 1ns/1ps
`include "cgmii_config.svh"

module cgmii_fsm
(
	input  logic                   i_clock,
	input  logic                   i_rst,
	input  logic [`NB_IDLE-1:0]    i_n_idle,
	input  logic [`NB_DATA-1:0]    i_n_data,
	output cgmii_pkg::fsm_state_e  o_state,
	output logic                   o_data_adv,
	output logic                   o_frame_end
);

localparam logic [`NB_CNT-1:0] INIT_LIMIT = `INIT_BLOCKS;
localparam logic [`NB_CNT-1:0] ONE        = 1;

cgmii_pkg::fsm_state_e  state;
cgmii_pkg::fsm_state_e  state_next;
logic [`NB_CNT-1:0]     cnt;        // blocks sent in the current state, from 1
logic [`NB_CNT-1:0]     cnt_limit;
logic                   cnt_done;

// length of the current state in blocks
always_comb
begin
	case (state)
		cgmii_pkg::ST_INIT:
		begin
			cnt_limit = INIT_LIMIT;
		end
		cgmii_pkg::ST_IDLE:
		begin
			cnt_limit = i_n_idle;
		end
		cgmii_pkg::ST_DATA:
		begin
			cnt_limit = {{(`NB_CNT-`NB_DATA){1'b0}}, i_n_data};
		end
		default:
		begin
			cnt_limit = ONE; // start and terminate are single blocks
		end
	endcase
end

assign cnt_done = (cnt == cnt_limit);

always_comb
begin
	case (state)
		cgmii_pkg::ST_INIT:  state_next = cgmii_pkg::ST_IDLE;
		cgmii_pkg::ST_IDLE:  state_next = cgmii_pkg::ST_START;
		cgmii_pkg::ST_START: state_next = cgmii_pkg::ST_DATA;
		cgmii_pkg::ST_DATA:  state_next = cgmii_pkg::ST_TERM;
		cgmii_pkg::ST_TERM:  state_next = cgmii_pkg::ST_IDLE;
		default:             state_next = cgmii_pkg::ST_INIT;
	endcase
end

always_ff @(posedge i_clock)
begin
	if (i_rst)
	begin
		state <= cgmii_pkg::ST_INIT;
		cnt   <= ONE;
	end
	else if (cnt_done)
	begin
		state <= state_next;
		cnt   <= ONE;
	end
	else
	begin
		cnt <= cnt + ONE;
	end
end

assign o_state     = state;
assign o_data_adv  = (state == cgmii_pkg::ST_DATA) || (state == cgmii_pkg::ST_TERM);
assign o_frame_end = (state == cgmii_pkg::ST_TERM); // terminate always lasts one cycle

endmodule

/* frame_gen/block_encoder.sv */
`timescale 1ns/1ps
`include "cgmii_config.svh"

module block_encoder
(
	input  logic                      i_clock,
	input  logic                      i_rst,
	input  cgmii_pkg::fsm_state_e     i_state,
	input  logic [`LEN_TX_DATA-1:0]   i_data_block,
	input  logic [`NB_TERM-1:0]       i_n_term,
	output logic [`LEN_TX_DATA-1:0]   o_tx_data,
	output logic [`LEN_TX_CTRL-1:0]   o_tx_ctrl
);

cgmii_pkg::blk_kind_e      kind;
logic [`LEN_TX_DATA-1:0]   term_data;
logic [`LEN_TX_CTRL-1:0]   term_ctrl;

always_comb
begin
	case (i_state)
		cgmii_pkg::ST_INIT:  kind = cgmii_pkg::BLK_ORD;
		cgmii_pkg::ST_START: kind = cgmii_pkg::BLK_START;
		cgmii_pkg::ST_DATA:  kind = cgmii_pkg::BLK_DATA;
		cgmii_pkg::ST_TERM:  kind = cgmii_pkg::BLK_TERM;
		default:             kind = cgmii_pkg::BLK_IDLE;
	endcase
end

// data lanes first, then T, then idle fill (T0 to T7)
always_comb
begin
	term_data = '0;
	for (int lane = 0; lane < `N_LANES; lane++)
	begin
		if (lane < i_n_term)
		begin
			term_data[`LEN_TX_DATA-1-lane*`LEN_CHAR -: `LEN_CHAR] =
				i_data_block[`LEN_TX_DATA-1-lane*`LEN_CHAR -: `LEN_CHAR];
		end
		else if (lane == i_n_term)
		begin
			term_data[`LEN_TX_DATA-1-lane*`LEN_CHAR -: `LEN_CHAR] = `TERM_CHAR;
		end
		else
		begin
			term_data[`LEN_TX_DATA-1-lane*`LEN_CHAR -: `LEN_CHAR] = `IDLE_CHAR;
		end
	end
end

assign term_ctrl = `IDLE_CTRL >> i_n_term; // data lanes drop out of the ctrl mask

always_ff @(posedge i_clock)
begin
	if (i_rst)
	begin
		o_tx_data <= {`N_LANES{`IDLE_CHAR}};
		o_tx_ctrl <= `IDLE_CTRL;
	end
	else
	begin
		case (kind)
			cgmii_pkg::BLK_ORD:
			begin
				o_tx_data <= `ORD_BLOCK;
				o_tx_ctrl <= `ORD_CTRL;
			end
			cgmii_pkg::BLK_START:
			begin
				o_tx_data <= `START_BLOCK;
				o_tx_ctrl <= `START_CTRL;
			end
			cgmii_pkg::BLK_DATA:
			begin
				o_tx_data <= i_data_block;
				o_tx_ctrl <= `DATA_CTRL;
			end
			cgmii_pkg::BLK_TERM:
			begin
				o_tx_data <= term_data;
				o_tx_ctrl <= term_ctrl;
			end
			default:
			begin
				o_tx_data <= {`N_LANES{`IDLE_CHAR}};
				o_tx_ctrl <= `IDLE_CTRL;
			end
		endcase
	end
end

endmodule

/* frame_gen/frame_generator.sv */
`timescale 1ns/1ps
`include "cgmii_config.svh"

module frame_generator
(
	input  logic                      i_clock,
	input  logic                      i_rst,
	output logic [`LEN_TX_DATA-1:0]   o_tx_data,
	output logic [`LEN_TX_CTRL-1:0]   o_tx_ctrl
);

cgmii_pkg::fsm_state_e     state;
logic                      data_adv;
logic                      frame_end;
logic [`LEN_TX_DATA-1:0]   data_block;
logic [`NB_IDLE-1:0]       n_idle;
logic [`NB_DATA-1:0]       n_data;
logic [`NB_TERM-1:0]       n_term;

cgmii_fsm u_cgmii_fsm
(
	.i_clock     (i_clock),
	.i_rst       (i_rst),
	.i_n_idle    (n_idle),
	.i_n_data    (n_data),
	.o_state     (state),
	.o_data_adv  (data_adv),
	.o_frame_end (frame_end)
);

block_encoder u_block_encoder
(
	.i_clock      (i_clock),
	.i_rst        (i_rst),
	.i_state      (state),
	.i_data_block (data_block),
	.i_n_term     (n_term),
	.o_tx_data    (o_tx_data),
	.o_tx_ctrl    (o_tx_ctrl)
);

data_generator u_data_generator
(
	.i_clock      (i_clock),
	.i_rst        (i_rst),
	.i_enable     (data_adv),   // data and terminate blocks consume bytes
	.o_data_block (data_block)
);

// new lengths for every frame
frame_rand u_frame_rand
(
	.i_clock  (i_clock),
	.i_rst    (i_rst),
	.i_step   (frame_end),
	.o_n_idle (n_idle),
	.o_n_data (n_data),
	.o_n_term (n_term)
);

endmodule

/* test/tb_frame_model.svh */
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

logic [15:0] model_lfsr; // length source of the frame being checked
logic [7:0]  exp_byte;   // expected lane 0 byte of the next data or terminate block

function automatic logic [31:0] lcg_next(input logic [31:0] x);
	return x * 32'd1103515245 + 32'd12345;
endfunction

// right shift, fold the taps in when a one drops out
function automatic logic [15:0] lfsr_step(input logic [15:0] r);
	if (r[0])
		return {1'b0, r[15:1]} ^ `LFSR_TAPS;
	return {1'b0, r[15:1]};
endfunction

function automatic int idle_len(input logic [15:0] r);
	return int'(r[3:0]) + 1;
endfunction

function automatic int data_len(input logic [15:0] r);
	return int'(r[6:4]) + 1;
endfunction

function automatic int term_len(input logic [15:0] r);
	return int'(r[9:7]);
endfunction

function automatic logic [63:0] data_block(input logic [7:0] first);
	logic [63:0] blk;
	for (int lane = 0; lane < 8; lane++)
		blk[63 - 8*lane -: 8] = first + 8'(lane);
	return blk;
endfunction

// n data lanes, then T, then idle fill
function automatic logic [63:0] term_block(input logic [7:0] first, input int n);
	logic [63:0] blk;
	for (int lane = 0; lane < 8; lane++)
	begin
		if (lane < n)
			blk[63 - 8*lane -: 8] = first + 8'(lane);
		else if (lane == n)
			blk[63 - 8*lane -: 8] = `TERM_CHAR;
		else
			blk[63 - 8*lane -: 8] = `IDLE_CHAR;
	end
	return blk;
endfunction

function automatic logic [7:0] term_ctrl(input int n);
	logic [7:0] ctrl;
	for (int lane = 0; lane < 8; lane++)
		ctrl[7 - lane] = (lane >= n); // control lanes from T onwards
	return ctrl;
endfunction

`endif

/* test/tb_frame_generator.sv */
`timescale 1ns/1ps
`include "cgmii_config.svh"

module tb_frame_generator;

localparam int RESET_CYCLES = 4;

typedef enum int {MON_WAIT, MON_ORD, MON_IDLE, MON_DATA} mon_phase_e;

logic        i_clock;
logic        i_rst;
logic [63:0] tx_data;
logic [7:0]  tx_ctrl;

mon_phase_e phase = MON_WAIT;
int ord_cnt = 0;
int idle_cnt = 0;
int data_cnt = 0;
int frames_done = 0;
int blocks_seen = 0;
int errors = 0;
int n_frames = 0;

`include "tb_frame_model.svh"

frame_generator i_frame_generator
(
	.i_clock   (i_clock),
	.i_rst     (i_rst),
	.o_tx_data (tx_data),
	.o_tx_ctrl (tx_ctrl)
);

initial
begin
	i_clock = 1'b0;
	i_rst   = 1'b1;
end

always #2 i_clock = ~i_clock;

task automatic compare_value(input string test_name, input logic [63:0] expected,
	input logic [63:0] actual);
	assert (expected == actual)
	else
	begin
		errors++;
		$display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
	end
endtask

task automatic expect_true(input bit cond, input string what);
	assert (cond)
	else
	begin
		errors++;
		$display("ERROR: %s", what);
	end
endtask

task automatic pulse_reset();
	@(posedge i_clock);
	i_rst <= 1'b1;
	repeat (RESET_CYCLES) @(posedge i_clock);
	i_rst <= 1'b0;
endtask

function automatic bit is_idle(input logic [63:0] d, input logic [7:0] c);
	return (c == `IDLE_CTRL) && (d == {8{`IDLE_CHAR}});
endfunction

function automatic bit is_ord(input logic [63:0] d, input logic [7:0] c);
	return (c == `ORD_CTRL) && (d[63:56] == 8'h9C);
endfunction

// one block per falling edge
always @(negedge i_clock)
begin
	if (i_rst)
	begin
		model_lfsr = `LFSR_SEED;
		exp_byte   = 8'd0;
		phase      = MON_WAIT;
	end
	else
	begin
		blocks_seen++;
		if (phase == MON_WAIT)
		begin
			if (is_ord(tx_data, tx_ctrl))
			begin
				phase   = MON_ORD;
				ord_cnt = 0;
			end
			else
				expect_true(is_idle(tx_data, tx_ctrl), "unexpected block before ordered sets");
		end
		if (phase == MON_ORD)
		begin
			if (is_ord(tx_data, tx_ctrl))
			begin
				ord_cnt++;
				compare_value("ordered set block", `ORD_BLOCK, tx_data);
			end
			else
			begin
				compare_value("ordered set count", 64'(`INIT_BLOCKS), 64'(ord_cnt));
				phase    = MON_IDLE;
				idle_cnt = 0;
			end
		end
		if (phase == MON_IDLE)
		begin
			if (is_idle(tx_data, tx_ctrl))
				idle_cnt++;
			else
			begin
				compare_value("idle gap length", 64'(idle_len(model_lfsr)), 64'(idle_cnt));
				compare_value("start block", `START_BLOCK, tx_data);
				compare_value("start ctrl", 64'(`START_CTRL), 64'(tx_ctrl));
				phase    = MON_DATA;
				data_cnt = 0;
			end
		end
		else if (phase == MON_DATA)
		begin
			if (tx_ctrl == `DATA_CTRL)
			begin
				data_cnt++;
				compare_value("data block", data_block(exp_byte), tx_data);
				exp_byte = exp_byte + 8'd8;
			end
			else
			begin
				compare_value("data block count", 64'(data_len(model_lfsr)), 64'(data_cnt));
				compare_value("terminate block", term_block(exp_byte, term_len(model_lfsr)),
					tx_data);
				compare_value("terminate ctrl", 64'(term_ctrl(term_len(model_lfsr))),
					64'(tx_ctrl));
				exp_byte   = exp_byte + 8'd8;
				model_lfsr = lfsr_step(model_lfsr);
				frames_done++;
				phase    = MON_IDLE;
				idle_cnt = 0;
			end
		end
	end
end

initial
begin
	logic [31:0] lcg;
	int reset_a;
	int reset_b;
	lcg      = lcg_next(32'h522e);
	n_frames = 40 + int'(lcg[20:16]);
	lcg      = lcg_next(lcg);
	reset_a  = 4 + int'(lcg[19:16]);
	lcg      = lcg_next(lcg);
	reset_b  = reset_a + 4 + int'(lcg[19:16]); // at most 38 so below any frame count
	repeat (RESET_CYCLES) @(posedge i_clock);
	i_rst <= 1'b0;
	wait (frames_done >= reset_a);
	pulse_reset();
	wait (frames_done >= reset_b);
	pulse_reset();
	wait (frames_done >= n_frames);
	@(posedge i_clock);
	$display("frames %0d, blocks %0d, errors %0d", frames_done, blocks_seen, errors);
	if (errors == 0)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

// longest frame is 26 blocks
initial
begin
	wait (n_frames > 0);
	repeat (n_frames * 30 + 50) @(posedge i_clock);
	$display("watchdog expired, the run hung before all frames were seen");
	$display("Test FAILED");
	$finish;
end

endmodule

/* all.f */
+incdir+common
+incdir+test
common/cgmii_pkg.sv
verilog/data_generator.sv
verilog/frame_rand.sv
frame_gen/cgmii_fsm.sv
frame_gen/block_encoder.sv
frame_gen/frame_generator.sv
test/tb_frame_generator.sv

/* run_sim.sh */
#!/bin/sh
# compile and run with verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module tb_frame_generator -o tb_sim \
	> build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "build or simulation run error, see build.log and sim.log"; exit 1; }
grep -qx "Test OK" sim.log &&
echo "simulation passed" ||
{ echo "simulation did not pass, see sim.log"; exit 1; }
